//--- compile.f
+incdir+verilog
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/hazardIf.sv
verilog/pipeReg.sv
verilog/controlUnit.sv
verilog/hazardUnit.sv
verilog/alu.sv
verilog/regFile.sv
verilog/memAlign.sv
verilog/pipeCpu.sv
sim/tbCpu.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f compile.f --top-module tbCpu -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/VtbCpu
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0

//--- sim/tbCpu.sv
`timescale 1ns/100ps

module tbCpu;

  localparam logic [6:0] opR = 7'b0110011;
  localparam logic [6:0] opImm = 7'b0010011;
  localparam logic [6:0] opLoad = 7'b0000011;
  localparam logic [6:0] opStore = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal = 7'b1101111;
  localparam logic [31:0] jalSelf = 32'h0000_006f; // jal x0, 0
  localparam logic [31:0] seed = 32'hf6d681be;
  localparam int progLen = 56; // 48 random plus 8 epilogue
  localparam int timeoutLimit = 6 * progLen + 40;

  logic clock;
  logic rstN;
  logic [31:0] imemAddr;
  logic [31:0] imemData;
  logic [31:0] dmemAddr;
  logic [31:0] dmemWdata;
  logic [3:0] dmemBe;
  logic dmemWe;
  logic [31:0] dmemRdata;

  logic [31:0] imem [64];
  logic [31:0] dmem [1024];
  logic [31:0] modelMem [1024];
  logic [31:0] modelReg [32];
  logic [31:0] expAddr [$];
  logic [3:0] expBe [$];
  logic [31:0] expData [$];
  logic [31:0] lfsr;
  int storeCount;
  int cycles;

  pipeCpu uut (
    .clock(clock), .rstN(rstN), .imemAddr(imemAddr), .imemData(imemData),
    .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemBe(dmemBe), .dmemWe(dmemWe),
    .dmemRdata(dmemRdata)
  );

  assign imemData = imem[imemAddr[7:2]];
  assign dmemRdata = dmem[dmemAddr[11:2]];

  always #10 clock = ~clock;

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr = lfsrNext(lfsr); // one step per bit
      bits = {bits[30:0], lfsr[0]};
    end
    return bits;
  endfunction

  function automatic logic [4:0] randSrc();
    logic [31:0] bits;
    bits = takeBits(3);
    return {2'b00, bits[2:0]};
  endfunction

  function automatic logic [4:0] randDest();
    logic [31:0] bits;
    bits = takeBits(3);
    return (bits[2:0] == 3'd0) ? 5'd7 : {2'b00, bits[2:0]}; // x1..x7
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, opJal};
  endfunction

  // forward skip of 2 to 4 instructions
  function automatic logic [12:0] skipOffset();
    logic [31:0] bits;
    logic [2:0] n;
    bits = takeBits(2);
    case (bits[1:0])
      2'd0: n = 3'd2;
      2'd2: n = 3'd4;
      default: n = 3'd3;
    endcase
    return {8'b0, n, 2'b00};
  endfunction

  // offset into the 64-word area at 0x400 aligned to the access size
  function automatic logic [11:0] memOffset(input logic [1:0] size);
    logic [31:0] bits;
    bits = takeBits(8);
    case (size)
      2'b00: return {4'h4, bits[7:0]};
      2'b01: return {4'h4, bits[7:1], 1'b0};
      default: return {4'h4, bits[7:2], 2'b00};
    endcase
  endfunction

  function automatic logic [31:0] arithR(input logic [4:0] src1);
    logic [31:0] bits;
    logic [6:0] f7;
    logic [4:0] rs2;
    logic [4:0] rd;
    bits = takeBits(4);
    f7 = ((bits[2:0] == 3'b000 || bits[2:0] == 3'b101) && bits[3]) ? 7'b0100000 : 7'b0;
    rs2 = randSrc();
    rd = randDest();
    return {f7, rs2, src1, bits[2:0], rd, opR};
  endfunction

  function automatic logic [31:0] arithI();
    logic [31:0] bits;
    logic [11:0] imm;
    logic [4:0] rs1;
    logic [4:0] rd;
    bits = takeBits(16);
    case (bits[2:0])
      3'b001: imm = {7'b0, bits[8:4]}; // slli
      3'b101: imm = {1'b0, bits[3], 5'b0, bits[8:4]}; // srli or srai
      default: imm = bits[15:4];
    endcase
    rs1 = randSrc();
    rd = randDest();
    return encI(imm, rs1, bits[2:0], rd, opImm);
  endfunction

  task automatic genProgram();
    int i;
    logic [31:0] bits;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3;
    for (int k = 0; k < 64; k++)
      imem[k] = 32'h0000_0013; // nop
    rd = 5'd0;
    for (int k = 0; k < 7; k++)
    begin
      rd = rd + 5'd1;
      bits = takeBits(12);
      imem[k] = encI(bits[11:0], 5'd0, 3'b000, rd, opImm); // seed x1..x7
    end
    i = 7;
    while (i < 48)
    begin
      bits = takeBits(3);
      case (bits[2:0])
        3'd0, 3'd1: imem[i] = arithR(randSrc());
        3'd2, 3'd3: imem[i] = arithI();
        3'd4:
        begin
          rd = randDest();
          bits = takeBits(3);
          f3 = (bits[1:0] == 2'b11 || bits[2:1] == 2'b11) ? 3'b010 : bits[2:0];
          imem[i] = encI(memOffset(f3[1:0]), 5'd0, f3, rd, opLoad);
          if (i < 47)
          begin
            i++;
            imem[i] = arithR(rd); // consumer right behind the load
          end
        end
        3'd5:
        begin
          bits = takeBits(2);
          f3 = bits[1] ? 3'b010 : {2'b00, bits[0]};
          rs2 = randSrc();
          imem[i] = encS(memOffset(f3[1:0]), rs2, 5'd0, f3);
        end
        3'd6:
        begin
          bits = takeBits(3);
          f3 = (bits[2:1] == 2'b01) ? {2'b00, bits[0]} : bits[2:0];
          rs1 = randSrc();
          rs2 = randSrc();
          imem[i] = encB(skipOffset(), rs2, rs1, f3);
        end
        default: imem[i] = encJ({8'b0, skipOffset()});
      endcase
      i++;
    end
    rd = 5'd0;
    for (int k = 48; k < 55; k++)
    begin
      rd = rd + 5'd1;
      imem[k] = encS(12'h5fc + {5'b0, rd, 2'b00}, rd, 5'd0, 3'b010); // x1..x7 to 0x600
    end
    imem[55] = jalSelf;
  endtask

  function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {31'b0, $signed(a) < $signed(b)};
      3'b011: return {31'b0, a < b};
      3'b100: return a ^ b;
      3'b101:
      begin
        if (alt)
          return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branchCond(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      3'b111: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int k = 0; k < 4; k++)
      if (be[k])
        res[8*k +: 8] = data[8*k +: 8];
    return res;
  endfunction

  task automatic writeReg(input logic [4:0] rd, input logic [31:0] value);
    if (rd != 5'd0)
      modelReg[rd] = value;
  endtask

  // ISA-level reference run that fills the expected store list and memory image
  task automatic runModel();
    logic [31:0] pc;
    logic [31:0] next;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] lane;
    logic [3:0] be;
    logic [2:0] f3;
    int steps;
    for (int k = 0; k < 32; k++)
      modelReg[k] = '0;
    pc = 32'h0;
    steps = 0;
    while (imem[pc[7:2]] != jalSelf && steps < 200)
    begin
      ins = imem[pc[7:2]];
      f3 = ins[14:12];
      a = modelReg[ins[19:15]];
      b = modelReg[ins[24:20]];
      immI = {{20{ins[31]}}, ins[31:20]};
      next = pc + 32'd4;
      case (ins[6:0])
        opR: writeReg(ins[11:7], aluRef(f3, ins[30], a, b));
        opImm: writeReg(ins[11:7], aluRef(f3, ins[30] && f3 == 3'b101, a, immI));
        opLoad:
        begin
          addr = a + immI;
          word = modelMem[addr[11:2]] >> {addr[1:0], 3'b000};
          case (f3)
            3'b000: writeReg(ins[11:7], {{24{word[7]}}, word[7:0]});
            3'b001: writeReg(ins[11:7], {{16{word[15]}}, word[15:0]});
            3'b100: writeReg(ins[11:7], {24'b0, word[7:0]});
            3'b101: writeReg(ins[11:7], {16'b0, word[15:0]});
            default: writeReg(ins[11:7], word);
          endcase
        end
        opStore:
        begin
          addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          case (f3)
            3'b000:
            begin
              be = 4'b0001 << addr[1:0];
              lane = {24'b0, b[7:0]} << {addr[1:0], 3'b000};
            end
            3'b001:
            begin
              be = 4'b0011 << addr[1:0];
              lane = {16'b0, b[15:0]} << {addr[1:0], 3'b000};
            end
            default:
            begin
              be = 4'b1111;
              lane = b;
            end
          endcase
          expAddr.push_back({addr[31:2], 2'b00});
          expBe.push_back(be);
          expData.push_back(lane);
          modelMem[addr[11:2]] = mergeBytes(modelMem[addr[11:2]], lane, be);
        end
        opBranch:
          if (branchCond(f3, a, b))
            next = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        opJal: next = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        default: ;
      endcase
      pc = next;
      steps++;
    end
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    if (got !== expected)
    begin
      $display("error at %0d ns: %s is %h, expected %h", $time, name, got, expected);
      $display("Checks failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // compare a store strobe with the next expected store, then commit it
  task automatic observeStore();
    logic [31:0] mask;
    if (dmemWe)
    begin
      if (storeCount >= expAddr.size())
      begin
        $display("a store appeared at %0d ns after all %0d expected stores", $time,
                 expAddr.size());
        $display("Checks failed");
        $fatal(1, "unexpected store");
      end
      mask = {{8{expBe[storeCount][3]}}, {8{expBe[storeCount][2]}},
              {8{expBe[storeCount][1]}}, {8{expBe[storeCount][0]}}};
      checkValue("dmemAddr", dmemAddr, expAddr[storeCount]);
      checkValue("dmemBe", {28'b0, dmemBe}, {28'b0, expBe[storeCount]});
      checkValue("dmemWdata", dmemWdata & mask, expData[storeCount] & mask); // enabled lanes only
      dmem[dmemAddr[11:2]] = mergeBytes(dmem[dmemAddr[11:2]], dmemWdata, dmemBe);
      storeCount++;
    end
  endtask

  initial
  begin
    clock = 1'b0;
    rstN = 1'b0;
    lfsr = seed;
    storeCount = 0;
    cycles = 0;
    for (int k = 0; k < 1024; k++)
    begin
      dmem[k] = ({20'b0, k[9:0], 2'b00} * 32'h9e37_79b9) ^ 32'h7f4a_7c15;
      modelMem[k] = dmem[k];
    end
    genProgram();
    runModel();
    repeat (2) @(negedge clock);
    rstN = 1'b1;
    while (storeCount < expAddr.size())
    begin
      @(negedge clock);
      cycles++;
      if (cycles > timeoutLimit)
      begin
        $display("timeout after %0d cycles with %0d of %0d expected stores seen", cycles,
                 storeCount, expAddr.size());
        $display("Checks failed");
        $fatal(1, "timeout");
      end
      observeStore();
    end
    repeat (10)
    begin
      @(negedge clock);
      observeStore(); // self loop must stay quiet
    end
    for (int k = 0; k < 1024; k++)
      checkValue($sformatf("dmem word %0d", k), dmem[k], modelMem[k]);
    $display("All checks passed");
    $finish;
  end

endmodule

//--- verilog/pipeCpu.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module pipeCpu (
  input  logic               clock,
  input  logic               rstN,
  output logic [`XLEN_W-1:0] imemAddr,
  input  logic [31:0]        imemData,
  output logic [`XLEN_W-1:0] dmemAddr,
  output logic [`XLEN_W-1:0] dmemWdata,
  output logic [3:0]         dmemBe,
  output logic               dmemWe,
  input  logic [`XLEN_W-1:0] dmemRdata
);

  hazardIf hz ();

  pipePkg::ifIdT  ifIdD, ifId;
  pipePkg::idExT  idExD, idEx;
  pipePkg::exMemT exMemD, exMem;
  pipePkg::memWbT memWbD, memWb;

  logic [`XLEN_W-1:0] pc;
  logic [`XLEN_W-1:0] pcNext;
  logic [31:0] idInstr;
  isaPkg::opcodeT idOpcode;
  pipePkg::ctrlT idCtrl;
  logic [`XLEN_W-1:0] idImm;
  logic [`XLEN_W-1:0] idRs1Data;
  logic [`XLEN_W-1:0] idRs2Data;
  isaPkg::opcodeT exOpcode;
  isaPkg::aluOpT exAluOp;
  logic exBrZ;
  logic exBrNz;
  logic [`XLEN_W-1:0] fwdA;
  logic [`XLEN_W-1:0] fwdB;
  logic [`XLEN_W-1:0] aluB;
  logic [`XLEN_W-1:0] aluResult;
  logic aluZero;
  logic [`XLEN_W-1:0] loadData;

  // fetch
  always_comb
  begin
    if (exMem.branchTaken)
      pcNext = exMem.branchTarget;
    else if (idCtrl.jump)
      pcNext = ifId.pc + idImm; // jal resolved in decode
    else
      pcNext = pc + 4;
  end

  always_ff @(posedge clock)
  begin
    if (!rstN)
      pc <= `RESET_PC;
    else if (hz.writePc)
      pc <= pcNext;
  end

  assign imemAddr = pc;
  assign ifIdD = '{pc: pc, instr: imemData};

  pipeReg #(.payloadT(pipePkg::ifIdT)) ifIdReg (
    .clock(clock), .rstN(rstN), .write(hz.writeIfId), .bubble(hz.bubbleIfId),
    .d(ifIdD), .q(ifId)
  );

  // decode
  assign idInstr = ifId.instr;
  assign idOpcode = isaPkg::opcodeT'(idInstr[6:0]);

  controlUnit idCtrlUnit (
    .opcode(idOpcode), .funct3(idInstr[14:12]), .funct7(idInstr[31:25]),
    .ctrl(idCtrl), .aluOp(), .branchOnZero(), .branchOnNonZero()
  );

  always_comb
  begin
    case (idOpcode)
      isaPkg::OP_STORE:  idImm = {{20{idInstr[31]}}, idInstr[31:25], idInstr[11:7]};
      isaPkg::OP_BRANCH: idImm = {{19{idInstr[31]}}, idInstr[31], idInstr[7], idInstr[30:25],
                                  idInstr[11:8], 1'b0};
      isaPkg::OP_JAL:    idImm = {{11{idInstr[31]}}, idInstr[31], idInstr[19:12], idInstr[20],
                                  idInstr[30:21], 1'b0};
      default:           idImm = {{20{idInstr[31]}}, idInstr[31:20]}; // I-type
    endcase
  end

  regFile regs (
    .clock(clock), .rstN(rstN),
    .readAddrA(idInstr[19:15]), .readAddrB(idInstr[24:20]),
    .writeEn(memWb.regWrite), .writeAddr(memWb.rd), .writeData(memWb.writeData),
    .readDataA(idRs1Data), .readDataB(idRs2Data)
  );

  hazardUnit hazards (
    .ifIdRs1(idInstr[19:15]), .ifIdRs2(idInstr[24:20]),
    .idExRd(idEx.rd), .idExMemRead(idEx.ctrl.memRead),
    .idExRs1(idEx.rs1), .idExRs2(idEx.rs2),
    .exMemRd(exMem.rd), .exMemRegWrite(exMem.ctrl.regWrite),
    .memWbRd(memWb.rd), .memWbRegWrite(memWb.regWrite),
    .jump(idCtrl.jump), .branchTaken(exMem.branchTaken),
    .hz(hz.hazard)
  );

  assign idExD = '{ctrl: idCtrl, pc: ifId.pc, rs1Data: idRs1Data, rs2Data: idRs2Data,
                   imm: idImm, rs1: idInstr[19:15], rs2: idInstr[24:20], rd: idInstr[11:7],
                   funct3: idInstr[14:12], funct7: idInstr[31:25]};

  pipeReg #(.payloadT(pipePkg::idExT)) idExReg (
    .clock(clock), .rstN(rstN), .write(hz.writeIdEx), .bubble(hz.bubbleIdEx),
    .d(idExD), .q(idEx)
  );

  // execute rebuilds the opcode class from the control bundle
  always_comb
  begin
    if (idEx.ctrl.branch)
      exOpcode = isaPkg::OP_BRANCH;
    else if (idEx.ctrl.aluClass == isaPkg::CLASS_ADDR)
      exOpcode = isaPkg::OP_LOAD;
    else if (idEx.ctrl.aluSrc)
      exOpcode = isaPkg::OP_IMM;
    else
      exOpcode = isaPkg::OP_R;
  end

  controlUnit exCtrlUnit (
    .opcode(exOpcode), .funct3(idEx.funct3), .funct7(idEx.funct7),
    .ctrl(), .aluOp(exAluOp), .branchOnZero(exBrZ), .branchOnNonZero(exBrNz)
  );

  always_comb
  begin
    case (hz.bypassA)
      pipePkg::BYP_MEM: fwdA = exMem.aluResult;
      pipePkg::BYP_WB:  fwdA = memWb.writeData;
      default:          fwdA = idEx.rs1Data;
    endcase
    case (hz.bypassB)
      pipePkg::BYP_MEM: fwdB = exMem.aluResult;
      pipePkg::BYP_WB:  fwdB = memWb.writeData;
      default:          fwdB = idEx.rs2Data;
    endcase
  end

  assign aluB = idEx.ctrl.aluSrc ? idEx.imm : fwdB;

  alu exAlu (
    .op(exAluOp), .a(fwdA), .b(aluB), .result(aluResult), .isZero(aluZero)
  );

  assign exMemD = '{ctrl: idEx.ctrl, aluResult: aluResult, storeData: fwdB,
                    branchTarget: idEx.pc + idEx.imm,
                    branchTaken: (exBrZ && aluZero) || (exBrNz && !aluZero),
                    funct3: idEx.funct3, rd: idEx.rd};

  pipeReg #(.payloadT(pipePkg::exMemT)) exMemReg (
    .clock(clock), .rstN(rstN), .write(1'b1), .bubble(hz.bubbleExMem),
    .d(exMemD), .q(exMem)
  );

  // memory
  memAlign align (
    .funct3(exMem.funct3), .addrLow(exMem.aluResult[1:0]),
    .storeData(exMem.storeData), .memRdata(dmemRdata),
    .loadData(loadData), .laneData(dmemWdata), .byteEnables(dmemBe)
  );

  assign dmemAddr = {exMem.aluResult[`XLEN_W-1:2], 2'b00}; // byte enables pick the lanes
  assign dmemWe = exMem.ctrl.memWrite;

  assign memWbD = '{regWrite: exMem.ctrl.regWrite,
                    writeData: exMem.ctrl.memToReg ? loadData : exMem.aluResult,
                    rd: exMem.rd};

  pipeReg #(.payloadT(pipePkg::memWbT)) memWbReg (
    .clock(clock), .rstN(rstN), .write(1'b1), .bubble(1'b0),
    .d(memWbD), .q(memWb)
  );

endmodule

//--- verilog/memAlign.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module memAlign (
  input  isaPkg::funct3T      funct3,
  input  logic [1:0]          addrLow,
  input  logic [`XLEN_W-1:0]  storeData,
  input  logic [`XLEN_W-1:0]  memRdata,
  output logic [`XLEN_W-1:0]  loadData,
  output logic [`XLEN_W-1:0]  laneData,
  output logic [3:0]          byteEnables
);

  logic [`XLEN_W-1:0] rdataShift;

  assign rdataShift = memRdata >> {addrLow, 3'b000}; // addressed lane down to bit 0

  always_comb
  begin
    case (funct3)
      isaPkg::F3_MEM_B:  loadData = {{24{rdataShift[7]}}, rdataShift[7:0]};
      isaPkg::F3_MEM_H:  loadData = {{16{rdataShift[15]}}, rdataShift[15:0]};
      isaPkg::F3_MEM_BU: loadData = {24'b0, rdataShift[7:0]};
      isaPkg::F3_MEM_HU: loadData = {16'b0, rdataShift[15:0]};
      default:           loadData = memRdata;
    endcase
  end

  always_comb
  begin
    case (funct3)
      isaPkg::F3_MEM_B:
      begin
        laneData = {4{storeData[7:0]}}; // copy to all lanes
        byteEnables = 4'b0001 << addrLow;
      end
      isaPkg::F3_MEM_H:
      begin
        laneData = {2{storeData[15:0]}};
        byteEnables = addrLow[1] ? 4'b1100 : 4'b0011;
      end
      isaPkg::F3_MEM_W:
      begin
        laneData = storeData;
        byteEnables = 4'b1111;
      end
      default:
      begin
        laneData = storeData;
        byteEnables = 4'b1111;
      end
    endcase
  end

endmodule

//--- verilog/regFile.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module regFile (
  input  logic               clock,
  input  logic               rstN,
  input  logic [`REG_AW-1:0] readAddrA,
  input  logic [`REG_AW-1:0] readAddrB,
  input  logic               writeEn,
  input  logic [`REG_AW-1:0] writeAddr,
  input  logic [`XLEN_W-1:0] writeData,
  output logic [`XLEN_W-1:0] readDataA,
  output logic [`XLEN_W-1:0] readDataB
);

  logic [`XLEN_W-1:0] regs [`REG_CNT];
  logic wrLive;

  assign wrLive = writeEn && (writeAddr != '0); // x0 never written

  always_ff @(posedge clock)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < `REG_CNT; i++)
        regs[i] <= '0;
    end
    else if (wrLive)
      regs[writeAddr] <= writeData;
  end

  // writeback visible in decode same cycle
  assign readDataA = (wrLive && writeAddr == readAddrA) ? writeData : regs[readAddrA];
  assign readDataB = (wrLive && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

//--- verilog/alu.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module alu (
  input  isaPkg::aluOpT       op,
  input  logic [`XLEN_W-1:0]  a,
  input  logic [`XLEN_W-1:0]  b,
  output logic [`XLEN_W-1:0]  result,
  output logic                isZero
);

  logic sLess;
  logic uLess;

  assign sLess = $signed(a) < $signed(b);
  assign uLess = a < b;

  always_comb
  begin
    case (op)
      isaPkg::ALU_ADD:  result = a + b;
      isaPkg::ALU_SUB:  result = a - b;
      isaPkg::ALU_XOR:  result = a ^ b;
      isaPkg::ALU_OR:   result = a | b;
      isaPkg::ALU_AND:  result = a & b;
      isaPkg::ALU_SLL:  result = a << b[4:0];
      isaPkg::ALU_SRL:  result = a >> b[4:0];
      isaPkg::ALU_SRA:  result = $signed(a) >>> b[4:0];
      isaPkg::ALU_SLT:  result = {{(`XLEN_W-1){1'b0}}, sLess};
      isaPkg::ALU_SLTU: result = {{(`XLEN_W-1){1'b0}}, uLess};
      isaPkg::ALU_BLT:  result = {{(`XLEN_W-1){1'b0}}, ~sLess}; // zero when a < b
      isaPkg::ALU_BLTU: result = {{(`XLEN_W-1){1'b0}}, ~uLess};
      default:          result = a + b;
    endcase
  end

  assign isZero = (result == '0);

endmodule

//--- verilog/hazardUnit.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module hazardUnit (
  input logic [`REG_AW-1:0] ifIdRs1,
  input logic [`REG_AW-1:0] ifIdRs2,
  input logic [`REG_AW-1:0] idExRd,
  input logic               idExMemRead,
  input logic [`REG_AW-1:0] idExRs1,
  input logic [`REG_AW-1:0] idExRs2,
  input logic [`REG_AW-1:0] exMemRd,
  input logic               exMemRegWrite,
  input logic [`REG_AW-1:0] memWbRd,
  input logic               memWbRegWrite,
  input logic               jump,
  input logic               branchTaken,
  hazardIf.hazard           hz
);

  logic loadUse;
  logic exMemFwd;
  logic memWbFwd;

  assign loadUse = idExMemRead && (idExRd != '0) && (idExRd == ifIdRs1 || idExRd == ifIdRs2);
  assign exMemFwd = exMemRegWrite && (exMemRd != '0);
  assign memWbFwd = memWbRegWrite && (memWbRd != '0);

  always_comb
  begin
    hz.writePc = 1'b1;
    hz.writeIfId = 1'b1;
    hz.writeIdEx = 1'b1;
    hz.bubbleIfId = 1'b0;
    hz.bubbleIdEx = 1'b0;
    hz.bubbleExMem = 1'b0;
    if (loadUse)
    begin
      hz.writePc = 1'b0; // hold fetch one cycle
      hz.writeIfId = 1'b0;
      hz.bubbleIdEx = 1'b1;
    end
    else if (jump)
      hz.bubbleIfId = 1'b1; // drop slot after jal
    if (branchTaken)
    begin
      hz.writePc = 1'b1; // wins over stall and jump
      hz.bubbleIfId = 1'b1;
      hz.bubbleIdEx = 1'b1;
      hz.bubbleExMem = 1'b1;
    end
  end

  // EX/MEM checked last so it wins
  always_comb
  begin
    hz.bypassA = pipePkg::BYP_RF;
    hz.bypassB = pipePkg::BYP_RF;
    if (memWbFwd && memWbRd == idExRs1)
      hz.bypassA = pipePkg::BYP_WB;
    if (memWbFwd && memWbRd == idExRs2)
      hz.bypassB = pipePkg::BYP_WB;
    if (exMemFwd && exMemRd == idExRs1)
      hz.bypassA = pipePkg::BYP_MEM;
    if (exMemFwd && exMemRd == idExRs2)
      hz.bypassB = pipePkg::BYP_MEM;
  end

endmodule

//--- verilog/controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
  input  isaPkg::opcodeT opcode,
  input  isaPkg::funct3T funct3,
  input  logic [6:0]     funct7,
  output pipePkg::ctrlT  ctrl,
  output isaPkg::aluOpT  aluOp,
  output logic           branchOnZero,
  output logic           branchOnNonZero
);

  always_comb
  begin
    ctrl = '0;
    case (opcode)
      isaPkg::OP_R:
      begin
        ctrl.regWrite = 1'b1;
        ctrl.aluClass = isaPkg::CLASS_REG_IMM;
      end
      isaPkg::OP_IMM:
      begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc = 1'b1;
        ctrl.aluClass = isaPkg::CLASS_REG_IMM;
      end
      isaPkg::OP_LOAD:
      begin
        ctrl.regWrite = 1'b1;
        ctrl.memRead = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.aluSrc = 1'b1;
        ctrl.aluClass = isaPkg::CLASS_ADDR;
      end
      isaPkg::OP_STORE:
      begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc = 1'b1;
        ctrl.aluClass = isaPkg::CLASS_ADDR;
      end
      isaPkg::OP_BRANCH:
      begin
        ctrl.branch = 1'b1;
        ctrl.aluClass = isaPkg::CLASS_BRANCH;
      end
      isaPkg::OP_JAL: ctrl.jump = 1'b1; // no link
      default: ctrl = '0;
    endcase
  end

  always_comb
  begin
    aluOp = isaPkg::ALU_ADD;
    case (ctrl.aluClass)
      isaPkg::CLASS_REG_IMM:
        case (funct3)
          isaPkg::F3_ADD_SUB: aluOp = (opcode == isaPkg::OP_R && funct7 == isaPkg::F7_ALT) ?
                                      isaPkg::ALU_SUB : isaPkg::ALU_ADD; // addi never subtracts
          isaPkg::F3_SLL:     aluOp = isaPkg::ALU_SLL;
          isaPkg::F3_SLT:     aluOp = isaPkg::ALU_SLT;
          isaPkg::F3_SLTU:    aluOp = isaPkg::ALU_SLTU;
          isaPkg::F3_XOR:     aluOp = isaPkg::ALU_XOR;
          isaPkg::F3_SRL_SRA: aluOp = (funct7 == isaPkg::F7_ALT) ? isaPkg::ALU_SRA : isaPkg::ALU_SRL;
          isaPkg::F3_OR:      aluOp = isaPkg::ALU_OR;
          default:            aluOp = isaPkg::ALU_AND;
        endcase
      isaPkg::CLASS_ADDR: aluOp = isaPkg::ALU_ADD;
      isaPkg::CLASS_BRANCH:
        case (funct3)
          isaPkg::F3_BLT, isaPkg::F3_BGE:   aluOp = isaPkg::ALU_BLT;
          isaPkg::F3_BLTU, isaPkg::F3_BGEU: aluOp = isaPkg::ALU_BLTU;
          default:                          aluOp = isaPkg::ALU_SUB; // beq, bne
        endcase
      default: aluOp = isaPkg::ALU_ADD;
    endcase
  end

  always_comb
  begin
    branchOnZero = 1'b0;
    branchOnNonZero = 1'b0;
    if (ctrl.branch)
    begin
      case (funct3)
        isaPkg::F3_BEQ, isaPkg::F3_BLT, isaPkg::F3_BLTU:  branchOnZero = 1'b1;
        isaPkg::F3_BNE, isaPkg::F3_BGE, isaPkg::F3_BGEU: branchOnNonZero = 1'b1;
        default: branchOnZero = 1'b0; // reserved encodings never branch
      endcase
    end
  end

endmodule

//--- verilog/pipeReg.sv
`timescale 1ns/100ps

module pipeReg #(
  parameter type payloadT = logic
) (
  input  logic    clock,
  input  logic    rstN,
  input  logic    write,
  input  logic    bubble,
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clock)
  begin
    if (!rstN || bubble)
    begin
      q <= '0; // zero payload has no control active
    end
    else if (write)
    begin
      q <= d;
    end
  end

endmodule

//--- verilog/hazardIf.sv
`timescale 1ns/100ps

interface hazardIf;
  logic writePc;
  logic writeIfId;
  logic writeIdEx;
  logic bubbleIfId;
  logic bubbleIdEx;
  logic bubbleExMem;
  logic [1:0] bypassA;
  logic [1:0] bypassB;

  modport hazard (
    output writePc, writeIfId, writeIdEx, bubbleIfId, bubbleIdEx, bubbleExMem,
    output bypassA, bypassB
  );

  modport core (
    input writePc, writeIfId, writeIdEx, bubbleIfId, bubbleIdEx, bubbleExMem,
    input bypassA, bypassB
  );
endinterface

//--- verilog/pipePkg.sv
`include "cpu_params.svh"

package pipePkg;

  typedef struct packed {
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic memToReg;
    logic aluSrc;
    logic branch;
    logic jump;
    isaPkg::aluClassT aluClass;
  } ctrlT;

  typedef struct packed {
    logic [`XLEN_W-1:0] pc;
    logic [31:0] instr;
  } ifIdT;

  typedef struct packed {
    ctrlT ctrl;
    logic [`XLEN_W-1:0] pc;
    logic [`XLEN_W-1:0] rs1Data;
    logic [`XLEN_W-1:0] rs2Data;
    logic [`XLEN_W-1:0] imm;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rd;
    isaPkg::funct3T funct3;
    logic [6:0] funct7;
  } idExT;

  typedef struct packed {
    ctrlT ctrl;
    logic [`XLEN_W-1:0] aluResult;
    logic [`XLEN_W-1:0] storeData;
    logic [`XLEN_W-1:0] branchTarget;
    logic branchTaken;
    isaPkg::funct3T funct3;
    logic [`REG_AW-1:0] rd;
  } exMemT;

  typedef struct packed {
    logic regWrite;
    logic [`XLEN_W-1:0] writeData;
    logic [`REG_AW-1:0] rd;
  } memWbT;

  // forwarding select values
  localparam logic [1:0] BYP_RF  = 2'd0;
  localparam logic [1:0] BYP_WB  = 2'd1;
  localparam logic [1:0] BYP_MEM = 2'd2;

endpackage

//--- verilog/isaPkg.sv
package isaPkg;

  typedef enum logic [6:0] {
    OP_R      = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcodeT;

  // funct3 means different things per opcode class
  typedef logic [2:0] funct3T;

  localparam funct3T F3_ADD_SUB = 3'b000;
  localparam funct3T F3_SLL     = 3'b001;
  localparam funct3T F3_SLT     = 3'b010;
  localparam funct3T F3_SLTU    = 3'b011;
  localparam funct3T F3_XOR     = 3'b100;
  localparam funct3T F3_SRL_SRA = 3'b101;
  localparam funct3T F3_OR      = 3'b110;
  localparam funct3T F3_AND     = 3'b111;

  localparam funct3T F3_BEQ  = 3'b000;
  localparam funct3T F3_BNE  = 3'b001;
  localparam funct3T F3_BLT  = 3'b100;
  localparam funct3T F3_BGE  = 3'b101;
  localparam funct3T F3_BLTU = 3'b110;
  localparam funct3T F3_BGEU = 3'b111;

  localparam funct3T F3_MEM_B  = 3'b000;
  localparam funct3T F3_MEM_H  = 3'b001;
  localparam funct3T F3_MEM_W  = 3'b010;
  localparam funct3T F3_MEM_BU = 3'b100;
  localparam funct3T F3_MEM_HU = 3'b101;

  localparam logic [6:0] F7_ALT = 7'b0100000; // sub / sra

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_BLT, ALU_BLTU
  } aluOpT;

  typedef enum logic [1:0] {
    CLASS_REG_IMM = 2'b00,
    CLASS_ADDR    = 2'b01,
    CLASS_BRANCH  = 2'b10
  } aluClassT;

endpackage

//--- verilog/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath width
`define XLEN_W 32

// register file address width
`define REG_AW 5

// architectural register count
`define REG_CNT 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif
